// ==== all.f ====
common/ppcPkg.sv
rtl/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
rtl/hazardUnit.sv
execute/executeStage.sv
rtl/memoryStage.sv
rtl/ppcCore.sv
bench/ppcCore_properties.sv
bench/tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' all.f)

obj_dir/Vtb: all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb -f all.f -o Vtb

run: obj_dir/Vtb
	out=$$(./obj_dir/Vtb); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== bench/tb.sv ====
module tb;
	import ppcPkg::*;

	logic clk;
	logic rst_n;
	logic loadStrobe;
	logic [IMEM_ADDR_W-1:0] loadAddr;
	logic [XLEN-1:0] loadWord;
	logic gprWrStrobe;
	logic [REG_ADDR_W-1:0] gprWrReg;
	logic [XLEN-1:0] gprWrData;
	logic storeStrobe;
	logic [XLEN-1:0] storeAddr;
	logic [XLEN-1:0] storeData;

	logic [31:0] lfsr;
	logic [31:0] prog[$];
	logic [36:0] gprQ[$]; // {reg, data}
	logic [63:0] stQ[$]; // {addr, data}
	logic [36:0] expGpr[$];
	logic [63:0] expSt[$];

	ppcCore i_dut (.*);

	bind ppcCore ppcCore_properties i_props (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// sample retirements mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (gprWrStrobe)
				gprQ.push_back({gprWrReg, gprWrData});
			if (storeStrobe)
				stQ.push_back({storeAddr, storeData});
		end
	end

	always @(negedge clk) begin
		if (i_dut.i_props.failCount != 0) begin
			$display("a bound property of the core failed");
			abortRun();
		end
	end

	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsrBit()};
		return v;
	endfunction

	function automatic logic [31:0] addiWord(input logic [4:0] rt, input logic [4:0] ra,
			input logic [15:0] si);
		return {6'd14, rt, ra, si};
	endfunction

	function automatic logic [31:0] xWord(input logic [4:0] rt, input logic [4:0] ra,
			input logic [4:0] rb, input logic [9:0] xo);
		return {6'd31, rt, ra, rb, xo, 1'b0};
	endfunction

	function automatic logic [31:0] memWord(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [15:0] d);
		return {op, rt, ra, d}; // lwz 32, stw 36
	endfunction

	function automatic logic [31:0] branchWord(input logic [23:0] li);
		return {6'd18, li, 2'b00};
	endfunction

	function automatic logic [31:0] bcWord(input logic [4:0] bo, input logic [4:0] bi,
			input logic [13:0] bd);
		return {6'd16, bo, bi, bd, 2'b00};
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	task automatic abortRun();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
			abortRun();
		end
	endtask

	task automatic expectWrite(input logic [4:0] r, input logic [31:0] d);
		expGpr.push_back({r, d});
	endtask

	task automatic expectStore(input logic [31:0] a, input logic [31:0] d);
		expSt.push_back({a, d});
	endtask

	// reset stretches while the program is still loading
	task automatic resetAndLoad();
		int n;
		n = (prog.size() > 5) ? prog.size() : 5;
		@(negedge clk);
		rst_n = 1'b0;
		gprQ.delete();
		stQ.delete();
		for (int i = 0; i < n; i++) begin
			loadStrobe = (i < prog.size());
			loadAddr = i[IMEM_ADDR_W-1:0];
			loadWord = (i < prog.size()) ? prog[i] : NOP_WORD;
			@(negedge clk);
		end
		loadStrobe = 1'b0;
		rst_n = 1'b1;
	endtask

	task automatic checkEvents();
		int cycles;
		cycles = 0;
		while ((gprQ.size() < expGpr.size() || stQ.size() < expSt.size()) && cycles < 300) begin
			@(posedge clk);
			cycles++;
		end
		if (gprQ.size() < expGpr.size() || stQ.size() < expSt.size()) begin
			$display("timeout: core retired fewer writes or stores than expected");
			abortRun();
		end
		repeat (12) @(posedge clk); // catch late extra writes
		checkVal("gpr write count", expGpr.size(), gprQ.size());
		checkVal("store count", expSt.size(), stQ.size());
		foreach (expGpr[i]) begin
			checkVal("gprWrReg", {27'b0, expGpr[i][36:32]}, {27'b0, gprQ[i][36:32]});
			checkVal("gprWrData", expGpr[i][31:0], gprQ[i][31:0]);
		end
		foreach (expSt[i]) begin
			checkVal("storeAddr", expSt[i][63:32], stQ[i][63:32]);
			checkVal("storeData", expSt[i][31:0], stQ[i][31:0]);
		end
	endtask

	task automatic startTest();
		prog.delete();
		expGpr.delete();
		expSt.delete();
	endtask

	task automatic testIdle();
		startTest();
		for (int i = 0; i < 56; i++)
			prog.push_back(NOP_WORD);
		resetAndLoad();
		repeat (50) @(posedge clk);
		checkVal("gpr write count", 0, gprQ.size());
		checkVal("store count", 0, stQ.size());
	endtask

	task automatic testAluChain();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r3;
		logic [31:0] r4;
		logic [31:0] r5;
		logic [31:0] r6;
		startTest();
		a = sext16(randBits(16));
		b = sext16(randBits(16));
		r3 = a + b;
		r4 = b - r3; // subf is rB - rA
		r5 = r4 & a;
		r6 = r5 | r3;
		prog = '{addiWord(1, 0, a[15:0]), addiWord(2, 0, b[15:0]), xWord(3, 1, 2, 10'd266),
			xWord(4, 3, 2, 10'd40), xWord(4, 5, 1, 10'd28), xWord(5, 6, 3, 10'd444),
			xWord(6, 7, 4, 10'd316), branchWord(0)};
		expectWrite(1, a);
		expectWrite(2, b);
		expectWrite(3, r3);
		expectWrite(4, r4);
		expectWrite(5, r5);
		expectWrite(6, r6);
		expectWrite(7, r6 ^ r4);
		resetAndLoad();
		checkEvents();
	endtask

	task automatic testLoadStore();
		logic [31:0] x;
		logic [31:0] y;
		startTest();
		x = sext16(randBits(16));
		y = sext16(randBits(16));
		prog = '{addiWord(1, 0, 16'h40), addiWord(2, 0, x[15:0]), addiWord(3, 0, y[15:0]),
			memWord(6'd36, 2, 1, 16'd0), memWord(6'd36, 3, 1, 16'd4),
			memWord(6'd32, 4, 1, 16'd4), xWord(5, 4, 2, 10'd266), branchWord(0)};
		expectWrite(1, 32'h40);
		expectWrite(2, x);
		expectWrite(3, y);
		expectWrite(4, y);
		expectWrite(5, y + x); // needs the load-use stall
		expectStore(32'h40, x);
		expectStore(32'h44, y);
		resetAndLoad();
		checkEvents();
	endtask

	task automatic testBranch();
		startTest();
		prog = '{addiWord(1, 0, 16'd5), addiWord(2, 0, 16'd5), addiWord(3, 0, 16'hfffd),
			xWord(0, 1, 2, 10'd0), bcWord(12, 2, 14'd3),
			addiWord(10, 0, 16'd1), addiWord(10, 0, 16'd2),
			bcWord(4, 2, 14'd3), addiWord(11, 0, 16'd7),
			xWord(0, 3, 1, 10'd0), bcWord(12, 0, 14'd3),
			addiWord(13, 0, 16'd9), addiWord(13, 0, 16'd10),
			bcWord(4, 0, 14'd3), addiWord(12, 0, 16'd8),
			bcWord(12, 2, 14'd3), addiWord(14, 0, 16'd11), branchWord(0)};
		expectWrite(1, 5);
		expectWrite(2, 5);
		expectWrite(3, 32'hffff_fffd);
		expectWrite(11, 7); // EQ set so branch-if-false falls through
		expectWrite(12, 8); // LT set so branch-if-false falls through
		expectWrite(14, 11); // EQ clear
		resetAndLoad();
		checkEvents();
	endtask

	task automatic testCountdown();
		logic [31:0] n;
		startTest();
		n = randBits(3) + 2;
		prog = '{addiWord(1, 0, n[15:0]), addiWord(1, 1, 16'hffff), xWord(0, 1, 0, 10'd0),
			bcWord(4, 2, 14'h3ffe), branchWord(24'd2), addiWord(9, 0, 16'h7ff),
			addiWord(8, 0, 16'd1), branchWord(0)};
		expectWrite(1, n);
		for (int i = n - 1; i >= 0; i--)
			expectWrite(1, i);
		expectWrite(8, 1);
		resetAndLoad();
		checkEvents();
	endtask

	initial begin
		rst_n = 1'b0;
		loadStrobe = 1'b0;
		loadAddr = '0;
		loadWord = '0;
		lfsr = 32'h121e;
		testIdle();
		testAluChain();
		testLoadStore();
		testBranch();
		testCountdown();
		if (i_dut.i_props.failCount == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			abortRun();
		end
	end

endmodule

// ==== bench/ppcCore_properties.sv ====
module ppcCore_properties (
	input logic clk,
	input logic rst_n,
	input logic gprWrStrobe,
	input logic [ppcPkg::REG_ADDR_W-1:0] gprWrReg,
	input logic [ppcPkg::XLEN-1:0] gprWrData,
	input logic storeStrobe,
	input logic [ppcPkg::XLEN-1:0] storeAddr
);
	int failCount = 0;

	quietInReset: assert property (@(posedge clk) !rst_n |-> !gprWrStrobe && !storeStrobe)
		else begin
			$error("strobe high during reset");
			failCount++;
		end

	// writeback triple must be clean when it retires
	wbKnown: assert property (@(posedge clk) disable iff (!rst_n)
			gprWrStrobe |-> !$isunknown({gprWrReg, gprWrData}))
		else begin
			$error("unknown writeback register or data");
			failCount++;
		end

	storeAligned: assert property (@(posedge clk) disable iff (!rst_n)
			storeStrobe |-> storeAddr[1:0] == 2'b00)
		else begin
			$error("store address not word aligned");
			failCount++;
		end

endmodule

// ==== rtl/ppcCore.sv ====
module ppcCore (
	input  logic clk,
	input  logic rst_n,
	input  logic loadStrobe,
	input  logic [ppcPkg::IMEM_ADDR_W-1:0] loadAddr,
	input  logic [ppcPkg::XLEN-1:0] loadWord,
	output logic gprWrStrobe,
	output logic [ppcPkg::REG_ADDR_W-1:0] gprWrReg,
	output logic [ppcPkg::XLEN-1:0] gprWrData,
	output logic storeStrobe,
	output logic [ppcPkg::XLEN-1:0] storeAddr,
	output logic [ppcPkg::XLEN-1:0] storeData
);
	import ppcPkg::*;

	instrWord_u fetchInstr;
	logic [XLEN-1:0] fetchPc;
	logic stall;
	logic branchTaken;
	logic [XLEN-1:0] branchTarget;

	logic [XLEN-1:0] exOpA;
	logic [XLEN-1:0] exOpB;
	logic [REG_ADDR_W-1:0] exSrcA;
	logic [REG_ADDR_W-1:0] exSrcB;
	logic [REG_ADDR_W-1:0] exDest;
	logic [XLEN-1:0] exImm;
	logic [XLEN-1:0] exPc;
	logic [ALU_OP_W-1:0] exAluOp;
	logic exUseImm;
	logic exWrites;
	logic exLoad;
	logic exStore;
	logic exCmp;
	logic exBranch;
	logic exCond;
	logic [4:0] exBo;
	logic [4:0] exBi;
	logic [XLEN-1:0] exBranchDisp;
	logic [REG_ADDR_W-1:0] decSrcA;
	logic [REG_ADDR_W-1:0] decSrcB;

	logic [FWD_W-1:0] fwdSelA;
	logic [FWD_W-1:0] fwdSelB;

	logic [XLEN-1:0] memResult;
	logic [XLEN-1:0] memStoreData;
	logic [REG_ADDR_W-1:0] memDest;
	logic memWrites;
	logic memLoad;
	logic memStore;

	fetchStage i_fetch (
		.clk(clk), .rst_n(rst_n),
		.loadStrobe(loadStrobe), .loadAddr(loadAddr), .loadWord(loadWord),
		.stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.fetchInstr(fetchInstr), .fetchPc(fetchPc)
	);

	// the writeback triple doubles as the gprWr outputs
	decodeStage i_decode (
		.clk(clk), .rst_n(rst_n),
		.fetchInstr(fetchInstr), .fetchPc(fetchPc),
		.stall(stall), .branchTaken(branchTaken),
		.wbStrobe(gprWrStrobe), .wbReg(gprWrReg), .wbData(gprWrData),
		.exOpA(exOpA), .exOpB(exOpB), .exSrcA(exSrcA), .exSrcB(exSrcB),
		.exDest(exDest), .exImm(exImm), .exPc(exPc), .exAluOp(exAluOp),
		.exUseImm(exUseImm), .exWrites(exWrites), .exLoad(exLoad), .exStore(exStore),
		.exCmp(exCmp), .exBranch(exBranch), .exCond(exCond),
		.exBo(exBo), .exBi(exBi), .exBranchDisp(exBranchDisp),
		.decSrcA(decSrcA), .decSrcB(decSrcB)
	);

	hazardUnit i_hazard (
		.decSrcA(decSrcA), .decSrcB(decSrcB),
		.exSrcA(exSrcA), .exSrcB(exSrcB), .exDest(exDest),
		.exWrites(exWrites), .exLoad(exLoad),
		.memDest(memDest), .memWrites(memWrites),
		.wbDest(gprWrReg), .wbWrites(gprWrStrobe),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .stall(stall)
	);

	executeStage i_execute (
		.clk(clk), .rst_n(rst_n),
		.exOpA(exOpA), .exOpB(exOpB), .exDest(exDest), .exImm(exImm), .exPc(exPc),
		.exAluOp(exAluOp), .exUseImm(exUseImm), .exWrites(exWrites), .exLoad(exLoad),
		.exStore(exStore), .exCmp(exCmp), .exBranch(exBranch), .exCond(exCond),
		.exBo(exBo), .exBi(exBi), .exBranchDisp(exBranchDisp),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .wbData(gprWrData),
		.memResult(memResult), .memStoreData(memStoreData), .memDest(memDest),
		.memWrites(memWrites), .memLoad(memLoad), .memStore(memStore),
		.branchTaken(branchTaken), .branchTarget(branchTarget)
	);

	memoryStage i_memory (
		.clk(clk), .rst_n(rst_n),
		.memResult(memResult), .memStoreData(memStoreData), .memDest(memDest),
		.memWrites(memWrites), .memLoad(memLoad), .memStore(memStore),
		.storeStrobe(storeStrobe), .storeAddr(storeAddr), .storeData(storeData),
		.wbStrobe(gprWrStrobe), .wbReg(gprWrReg), .wbData(gprWrData)
	);

endmodule

// ==== rtl/memoryStage.sv ====
module memoryStage (
	input  logic clk,
	input  logic rst_n,
	input  logic [ppcPkg::XLEN-1:0] memResult,
	input  logic [ppcPkg::XLEN-1:0] memStoreData,
	input  logic [ppcPkg::REG_ADDR_W-1:0] memDest,
	input  logic memWrites,
	input  logic memLoad,
	input  logic memStore,
	output logic storeStrobe,
	output logic [ppcPkg::XLEN-1:0] storeAddr,
	output logic [ppcPkg::XLEN-1:0] storeData,
	output logic wbStrobe,
	output logic [ppcPkg::REG_ADDR_W-1:0] wbReg,
	output logic [ppcPkg::XLEN-1:0] wbData
);
	import ppcPkg::*;

	logic [XLEN-1:0] dmem [2**DMEM_ADDR_W];
	logic [DMEM_ADDR_W-1:0] wordIdx;
	logic [XLEN-1:0] readData;

	assign wordIdx = memResult[DMEM_ADDR_W+1:2];
	assign readData = dmem[wordIdx]; // async read

	always_ff @(posedge clk) begin
		if (memStore)
			dmem[wordIdx] <= memStoreData;
	end

	assign storeStrobe = memStore;
	assign storeAddr = {memResult[XLEN-1:2], 2'b00}; // word aligned
	assign storeData = memStoreData;

	// memory/writeback register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wbStrobe <= 1'b0;
		else
			wbStrobe <= memWrites;
	end

	always_ff @(posedge clk) begin
		wbReg <= memDest;
		wbData <= memLoad ? readData : memResult;
	end

endmodule

// ==== execute/executeStage.sv ====
module executeStage (
	input  logic clk,
	input  logic rst_n,
	input  logic [ppcPkg::XLEN-1:0] exOpA,
	input  logic [ppcPkg::XLEN-1:0] exOpB,
	input  logic [ppcPkg::REG_ADDR_W-1:0] exDest,
	input  logic [ppcPkg::XLEN-1:0] exImm,
	input  logic [ppcPkg::XLEN-1:0] exPc,
	input  logic [ppcPkg::ALU_OP_W-1:0] exAluOp,
	input  logic exUseImm,
	input  logic exWrites,
	input  logic exLoad,
	input  logic exStore,
	input  logic exCmp,
	input  logic exBranch,
	input  logic exCond,
	input  logic [4:0] exBo,
	input  logic [4:0] exBi,
	input  logic [ppcPkg::XLEN-1:0] exBranchDisp,
	input  logic [ppcPkg::FWD_W-1:0] fwdSelA,
	input  logic [ppcPkg::FWD_W-1:0] fwdSelB,
	input  logic [ppcPkg::XLEN-1:0] wbData,
	output logic [ppcPkg::XLEN-1:0] memResult,
	output logic [ppcPkg::XLEN-1:0] memStoreData,
	output logic [ppcPkg::REG_ADDR_W-1:0] memDest,
	output logic memWrites,
	output logic memLoad,
	output logic memStore,
	output logic branchTaken,
	output logic [ppcPkg::XLEN-1:0] branchTarget
);
	import ppcPkg::*;

	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] aluB;
	logic [XLEN-1:0] aluResult;
	logic [0:3] cr0; // LT GT EQ SO, ISA bit order
	logic crBit;

	function automatic logic [XLEN-1:0] fwdMux(input logic [FWD_W-1:0] sel,
			input logic [XLEN-1:0] regVal);
		case (sel)
			FWD_MEM: return memResult;
			FWD_WB: return wbData;
			default: return regVal;
		endcase
	endfunction

	assign opA = fwdMux(fwdSelA, exOpA);
	assign opB = fwdMux(fwdSelB, exOpB);
	assign aluB = exUseImm ? exImm : opB;

	always_comb begin
		case (exAluOp)
			ALU_ADD: aluResult = opA + aluB;
			ALU_SUBF: aluResult = aluB - opA;
			ALU_AND: aluResult = opA & aluB;
			ALU_OR: aluResult = opA | aluB;
			ALU_XOR: aluResult = opA ^ aluB;
			ALU_PASSB: aluResult = aluB;
			default: aluResult = '0;
		endcase
	end

	// signed word compare, SO never set
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cr0 <= '0;
		else if (exCmp)
			cr0 <= {$signed(opA) < $signed(opB), $signed(opA) > $signed(opB), opA == opB, 1'b0};
	end

	assign crBit = cr0[exBi[1:0]];
	// bo[3] is the condition sense bit
	assign branchTaken = exBranch && (!exCond || crBit == exBo[3]);
	assign branchTarget = exPc + (exBranchDisp << 2);

	// execute/memory register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			memWrites <= 1'b0;
			memLoad <= 1'b0;
			memStore <= 1'b0;
		end else begin
			memWrites <= exWrites;
			memLoad <= exLoad;
			memStore <= exStore;
		end
	end

	always_ff @(posedge clk) begin
		memResult <= aluResult;
		memStoreData <= opB;
		memDest <= exDest;
	end

endmodule

// ==== rtl/hazardUnit.sv ====
module hazardUnit (
	input  logic [ppcPkg::REG_ADDR_W-1:0] decSrcA,
	input  logic [ppcPkg::REG_ADDR_W-1:0] decSrcB,
	input  logic [ppcPkg::REG_ADDR_W-1:0] exSrcA,
	input  logic [ppcPkg::REG_ADDR_W-1:0] exSrcB,
	input  logic [ppcPkg::REG_ADDR_W-1:0] exDest,
	input  logic exWrites,
	input  logic exLoad,
	input  logic [ppcPkg::REG_ADDR_W-1:0] memDest,
	input  logic memWrites,
	input  logic [ppcPkg::REG_ADDR_W-1:0] wbDest,
	input  logic wbWrites,
	output logic [ppcPkg::FWD_W-1:0] fwdSelA,
	output logic [ppcPkg::FWD_W-1:0] fwdSelB,
	output logic stall
);
	import ppcPkg::*;

	// youngest writer wins
	function automatic logic [FWD_W-1:0] pickFwd(input logic [REG_ADDR_W-1:0] src);
		if (memWrites && memDest == src)
			return FWD_MEM;
		else if (wbWrites && wbDest == src)
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign fwdSelA = pickFwd(exSrcA);
	assign fwdSelB = pickFwd(exSrcB);

	// load data only exists after the memory stage
	assign stall = exLoad && exWrites && (exDest == decSrcA || exDest == decSrcB);

endmodule

// ==== decode/decodeStage.sv ====
module decodeStage (
	input  logic clk,
	input  logic rst_n,
	input  ppcPkg::instrWord_u fetchInstr,
	input  logic [ppcPkg::XLEN-1:0] fetchPc,
	input  logic stall,
	input  logic branchTaken,
	input  logic wbStrobe,
	input  logic [ppcPkg::REG_ADDR_W-1:0] wbReg,
	input  logic [ppcPkg::XLEN-1:0] wbData,
	output logic [ppcPkg::XLEN-1:0] exOpA,
	output logic [ppcPkg::XLEN-1:0] exOpB,
	output logic [ppcPkg::REG_ADDR_W-1:0] exSrcA,
	output logic [ppcPkg::REG_ADDR_W-1:0] exSrcB,
	output logic [ppcPkg::REG_ADDR_W-1:0] exDest,
	output logic [ppcPkg::XLEN-1:0] exImm,
	output logic [ppcPkg::XLEN-1:0] exPc,
	output logic [ppcPkg::ALU_OP_W-1:0] exAluOp,
	output logic exUseImm,
	output logic exWrites,
	output logic exLoad,
	output logic exStore,
	output logic exCmp,
	output logic exBranch,
	output logic exCond,
	output logic [4:0] exBo,
	output logic [4:0] exBi,
	output logic [ppcPkg::XLEN-1:0] exBranchDisp,
	output logic [ppcPkg::REG_ADDR_W-1:0] decSrcA,
	output logic [ppcPkg::REG_ADDR_W-1:0] decSrcB
);
	import ppcPkg::*;

	logic [XLEN-1:0] rdA;
	logic [XLEN-1:0] rdB;
	logic [23:0] li;
	logic [REG_ADDR_W-1:0] dest;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] disp;
	logic [ALU_OP_W-1:0] aluOp;
	logic useImm;
	logic writes;
	logic isLoad;
	logic isStore;
	logic isCmp;
	logic isBranch;
	logic isCond;
	logic bubble;

	regFile i_regFile (
		.clk(clk), .rst_n(rst_n),
		.rdAddrA(decSrcA), .rdAddrB(decSrcB),
		.wrStrobe(wbStrobe), .wrAddr(wbReg), .wrData(wbData),
		.rdDataA(rdA), .rdDataB(rdB)
	);

	// I-form LI field
	assign li = {fetchInstr.dForm.rt, fetchInstr.dForm.ra, fetchInstr.dForm.d16[15:2]};
	assign bubble = stall || branchTaken;

	always_comb begin
		decSrcA = fetchInstr.xForm.ra;
		decSrcB = fetchInstr.xForm.rb;
		dest = fetchInstr.xForm.rt;
		imm = {{16{fetchInstr.dForm.d16[15]}}, fetchInstr.dForm.d16};
		disp = {{18{fetchInstr.bForm.bd14[13]}}, fetchInstr.bForm.bd14};
		aluOp = ALU_ADD;
		useImm = 1'b0;
		writes = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isCmp = 1'b0;
		isBranch = 1'b0;
		isCond = 1'b0;
		case (fetchInstr.dForm.opcd)
			OP_ADDI: begin
				useImm = 1'b1;
				writes = 1'b1;
				if (fetchInstr.dForm.ra == '0)
					aluOp = ALU_PASSB; // rA = 0 reads as zero
			end
			OP_LWZ: begin
				useImm = 1'b1;
				writes = 1'b1;
				isLoad = 1'b1;
				if (fetchInstr.dForm.ra == '0)
					aluOp = ALU_PASSB;
			end
			OP_STW: begin
				useImm = 1'b1;
				isStore = 1'b1;
				decSrcB = fetchInstr.dForm.rt; // rS gives the store data
				if (fetchInstr.dForm.ra == '0)
					aluOp = ALU_PASSB;
			end
			OP_X: begin
				case (fetchInstr.xForm.xo)
					XO_ADD: writes = 1'b1;
					XO_SUBF: begin
						aluOp = ALU_SUBF;
						writes = 1'b1;
					end
					XO_AND, XO_OR, XO_XOR: begin
						decSrcA = fetchInstr.xForm.rt; // logicals are rA = rS op rB
						dest = fetchInstr.xForm.ra;
						writes = 1'b1;
						if (fetchInstr.xForm.xo == XO_AND)
							aluOp = ALU_AND;
						else if (fetchInstr.xForm.xo == XO_OR)
							aluOp = ALU_OR;
						else
							aluOp = ALU_XOR;
					end
					XO_CMP: isCmp = 1'b1; // BF ignored, CR0 only
					default: ;
				endcase
			end
			OP_B: begin
				isBranch = 1'b1;
				disp = {{8{li[23]}}, li};
			end
			OP_BC: begin
				isBranch = 1'b1;
				isCond = 1'b1;
			end
			default: ;
		endcase
	end

	// decode/execute register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exWrites <= 1'b0;
			exLoad <= 1'b0;
			exStore <= 1'b0;
			exCmp <= 1'b0;
			exBranch <= 1'b0;
		end else begin
			exWrites <= writes && !bubble;
			exLoad <= isLoad && !bubble;
			exStore <= isStore && !bubble;
			exCmp <= isCmp && !bubble;
			exBranch <= isBranch && !bubble;
		end
	end

	always_ff @(posedge clk) begin
		exOpA <= rdA;
		exOpB <= rdB;
		exSrcA <= decSrcA;
		exSrcB <= decSrcB;
		exDest <= dest;
		exImm <= imm;
		exPc <= fetchPc;
		exAluOp <= aluOp;
		exUseImm <= useImm;
		exCond <= isCond;
		exBo <= fetchInstr.bForm.bo;
		exBi <= fetchInstr.bForm.bi;
		exBranchDisp <= disp;
	end

endmodule

// ==== decode/regFile.sv ====
module regFile (
	input  logic clk,
	input  logic rst_n,
	input  logic [ppcPkg::REG_ADDR_W-1:0] rdAddrA,
	input  logic [ppcPkg::REG_ADDR_W-1:0] rdAddrB,
	input  logic wrStrobe,
	input  logic [ppcPkg::REG_ADDR_W-1:0] wrAddr,
	input  logic [ppcPkg::XLEN-1:0] wrData,
	output logic [ppcPkg::XLEN-1:0] rdDataA,
	output logic [ppcPkg::XLEN-1:0] rdDataB
);
	import ppcPkg::*;

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++)
				regs[i] <= '0;
		end else if (wrStrobe) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through so decode sees this cycle's writeback
	assign rdDataA = (wrStrobe && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrStrobe && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== rtl/fetchStage.sv ====
module fetchStage (
	input  logic clk,
	input  logic rst_n,
	input  logic loadStrobe,
	input  logic [ppcPkg::IMEM_ADDR_W-1:0] loadAddr,
	input  logic [ppcPkg::XLEN-1:0] loadWord,
	input  logic stall,
	input  logic branchTaken,
	input  logic [ppcPkg::XLEN-1:0] branchTarget,
	output ppcPkg::instrWord_u fetchInstr,
	output logic [ppcPkg::XLEN-1:0] fetchPc
);
	import ppcPkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] imem [2**IMEM_ADDR_W];
	logic [XLEN-1:0] imemWord;

	always_ff @(posedge clk) begin
		if (loadStrobe)
			imem[loadAddr] <= loadWord;
	end

	assign imemWord = imem[pc[IMEM_ADDR_W+1:2]]; // byte pc to word index

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (branchTaken)
			pc <= branchTarget;
		else if (!stall)
			pc <= pc + 32'd4;
	end

	// fetch/decode register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fetchInstr <= NOP_WORD;
		else if (branchTaken)
			fetchInstr <= NOP_WORD; // squash wrong-path word
		else if (!stall)
			fetchInstr <= imemWord;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			fetchPc <= pc;
	end

endmodule

// ==== common/ppcPkg.sv ====
package ppcPkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMEM_ADDR_W = 8; // 256 words
	localparam int DMEM_ADDR_W = 8;

	// primary opcodes
	localparam logic [5:0] OP_ADDI = 6'd14;
	localparam logic [5:0] OP_X = 6'd31;
	localparam logic [5:0] OP_LWZ = 6'd32;
	localparam logic [5:0] OP_STW = 6'd36;
	localparam logic [5:0] OP_B = 6'd18;
	localparam logic [5:0] OP_BC = 6'd16;

	// extended opcodes under OP_X
	localparam logic [9:0] XO_ADD = 10'd266;
	localparam logic [9:0] XO_SUBF = 10'd40;
	localparam logic [9:0] XO_AND = 10'd28;
	localparam logic [9:0] XO_OR = 10'd444;
	localparam logic [9:0] XO_XOR = 10'd316;
	localparam logic [9:0] XO_CMP = 10'd0;

	localparam logic [XLEN-1:0] NOP_WORD = 32'h6000_0000; // ori 0,0,0

	localparam int ALU_OP_W = 3;
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUBF = 3'd1; // b - a
	localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 3'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
	localparam logic [ALU_OP_W-1:0] ALU_PASSB = 3'd5;

	localparam int FWD_W = 2;
	localparam logic [FWD_W-1:0] FWD_REG = 2'd0;
	localparam logic [FWD_W-1:0] FWD_MEM = 2'd1;
	localparam logic [FWD_W-1:0] FWD_WB = 2'd2;

	// field order follows the ISA, bit 0 is the msb
	typedef union packed {
		struct packed {
			logic [5:0] opcd;
			logic [4:0] rt;
			logic [4:0] ra;
			logic [15:0] d16;
		} dForm;
		struct packed {
			logic [5:0] opcd;
			logic [4:0] rt;
			logic [4:0] ra;
			logic [4:0] rb;
			logic [9:0] xo;
			logic rc;
		} xForm;
		struct packed {
			logic [5:0] opcd;
			logic [4:0] bo;
			logic [4:0] bi;
			logic [13:0] bd14;
			logic aa;
			logic lk;
		} bForm;
	} instrWord_u;

endpackage
